// File: rrag_mem_defs.svh
`ifndef RRAG_MEM_DEFS_SVH
`define RRAG_MEM_DEFS_SVH

// data and address width.
`define RM_XLEN 32

// general register file.
`define RM_NREGS 8
`define RM_RIDX_W 3

// segment base registers.
`define RM_NSEGS 4
`define RM_SIDX_W 2

// data memory, 32-bit words.
`define RM_MEM_WORDS 256
`define RM_MEM_AW 8

// byte lanes per word.
`define RM_LANES 4

`endif

// File: rrag_mem_pkg.sv
package rrag_mem_pkg;

    // memory operation carried down the pipe.
    typedef enum logic [1:0] {
        op_lea   = 2'b00,
        op_load  = 2'b01,
        op_store = 2'b10
    } mem_op_e;

    // operand size, 1, 2 or 4 bytes.
    typedef enum logic [1:0] {
        size_byte  = 2'b00,
        size_word  = 2'b01,
        size_dword = 2'b10
    } opsize_e;

    // memory stage sequencing.
    typedef enum logic {
        st_access = 1'b0,
        st_second = 1'b1
    } mem_state_e;

    // offset of the operand's last byte from its first.
    function automatic logic [1:0] last_byte_off(opsize_e size);
        logic [1:0] off;
        case (size)
            size_byte:  off = 2'd0;
            size_word:  off = 2'd1;
            default:    off = 2'd3;
        endcase
        return off;
    endfunction

endpackage

// File: reg_file.sv
`include "rrag_mem_defs.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  arst_n,

    // general register reads.
    input  logic [`RM_RIDX_W-1:0] rd_a_idx,
    input  logic [`RM_RIDX_W-1:0] rd_b_idx,
    input  logic [`RM_RIDX_W-1:0] rd_c_idx,
    output logic [`RM_XLEN-1:0]   rd_a,
    output logic [`RM_XLEN-1:0]   rd_b,
    output logic [`RM_XLEN-1:0]   rd_c,

    // writeback from outside the slice.
    input  logic                  wb_en,
    input  logic [`RM_RIDX_W-1:0] wb_idx,
    input  logic [`RM_XLEN-1:0]   wb_data,
    input  logic                  seg_wr_en,
    input  logic [`RM_SIDX_W-1:0] seg_wr_idx,
    input  logic [`RM_XLEN-1:0]   seg_wr_data,

    // segment base read.
    input  logic [`RM_SIDX_W-1:0] seg_sel,
    output logic [`RM_XLEN-1:0]   seg_base
);

    logic [`RM_XLEN-1:0] gpr [0:`RM_NREGS-1];
    logic [`RM_XLEN-1:0] seg [0:`RM_NSEGS-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RM_NREGS; i++) begin
                gpr[i] <= '0;
            end
        end else if (wb_en) begin
            gpr[wb_idx] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RM_NSEGS; i++) begin
                seg[i] <= '0;
            end
        end else if (seg_wr_en) begin
            seg[seg_wr_idx] <= seg_wr_data;
        end
    end

    // reads are combinational, a write shows up after its edge.
    assign rd_a     = gpr[rd_a_idx];
    assign rd_b     = gpr[rd_b_idx];
    assign rd_c     = gpr[rd_c_idx];
    assign seg_base = seg[seg_sel];

endmodule

// File: addr_gen.sv
`include "rrag_mem_defs.svh"

module addr_gen (
    input  logic [`RM_XLEN-1:0]  seg_base,
    input  logic [`RM_XLEN-1:0]  base,
    input  logic [`RM_XLEN-1:0]  index,
    input  logic [1:0]           scale,
    input  logic [`RM_XLEN-1:0]  disp,
    input  rrag_mem_pkg::opsize_e size,
    output logic [`RM_XLEN-1:0]  lin_addr,
    output logic [`RM_XLEN-1:0]  end_addr
);

    logic [`RM_XLEN-1:0] scaled_index;
    logic [`RM_XLEN-1:0] eff_addr;
    logic [1:0]          last_off;

    // index times 1, 2, 4 or 8.
    always_comb begin
        case (scale)
            2'd0:    scaled_index = index;
            2'd1:    scaled_index = {index[`RM_XLEN-2:0], 1'b0};
            2'd2:    scaled_index = {index[`RM_XLEN-3:0], 2'b00};
            default: scaled_index = {index[`RM_XLEN-4:0], 3'b000};
        endcase
    end

    // effective address within the segment.
    assign eff_addr = base + scaled_index + disp;

    // all sums wrap modulo 2^32.
    assign lin_addr = seg_base + eff_addr;

    assign last_off = rrag_mem_pkg::last_byte_off(size);
    assign end_addr = lin_addr + {{(`RM_XLEN-2){1'b0}}, last_off};

endmodule

// File: rrag_stage.sv
`include "rrag_mem_defs.svh"

module rrag_stage (
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic                   in_valid,
    input  rrag_mem_pkg::mem_op_e  in_op,
    input  rrag_mem_pkg::opsize_e  in_size,
    input  logic [`RM_RIDX_W-1:0]  base_idx,
    input  logic [`RM_RIDX_W-1:0]  index_idx,
    input  logic [1:0]             scale,
    input  logic [`RM_XLEN-1:0]    disp,
    input  logic [`RM_SIDX_W-1:0]  seg_sel,
    input  logic [`RM_RIDX_W-1:0]  data_idx,
    input  logic [`RM_RIDX_W-1:0]  dest_idx,
    input  logic [`RM_XLEN-1:0]    eip,

    input  logic                   wb_en,
    input  logic [`RM_RIDX_W-1:0]  wb_idx,
    input  logic [`RM_XLEN-1:0]    wb_data,
    input  logic                   seg_wr_en,
    input  logic [`RM_SIDX_W-1:0]  seg_wr_idx,
    input  logic [`RM_XLEN-1:0]    seg_wr_data,

    output logic                   valid_out,
    output rrag_mem_pkg::mem_op_e  op_out,
    output rrag_mem_pkg::opsize_e  size_out,
    output logic [`RM_XLEN-1:0]    addr_out,
    output logic [`RM_XLEN-1:0]    end_addr_out,
    output logic [`RM_XLEN-1:0]    store_data_out,
    output logic [`RM_RIDX_W-1:0]  dest_out,
    output logic [`RM_XLEN-1:0]    eip_out
);

    logic [`RM_XLEN-1:0] base_val;
    logic [`RM_XLEN-1:0] index_val;
    logic [`RM_XLEN-1:0] data_val;
    logic [`RM_XLEN-1:0] seg_base;

    reg_file u_reg_file (
        .clk(clk), .arst_n(arst_n),
        .rd_a_idx(base_idx), .rd_b_idx(index_idx), .rd_c_idx(data_idx),
        .rd_a(base_val), .rd_b(index_val), .rd_c(data_val),
        .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data),
        .seg_wr_en(seg_wr_en), .seg_wr_idx(seg_wr_idx), .seg_wr_data(seg_wr_data),
        .seg_sel(seg_sel), .seg_base(seg_base)
    );

    addr_gen u_addr_gen (
        .seg_base(seg_base), .base(base_val), .index(index_val),
        .scale(scale), .disp(disp), .size(in_size),
        .lin_addr(addr_out), .end_addr(end_addr_out)
    );

    assign valid_out = in_valid;
    assign op_out    = in_op;
    assign size_out  = in_size;
    assign dest_out  = dest_idx;
    assign eip_out   = eip;

    // only stores carry register data down.
    assign store_data_out = (in_op == rrag_mem_pkg::op_store) ? data_val : '0;

endmodule

// File: rrag_mem_latch.sv
`include "rrag_mem_defs.svh"

module rrag_mem_latch (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   stall,
    input  logic                   flush,

    input  logic                   valid_in,
    input  rrag_mem_pkg::mem_op_e  op_in,
    input  rrag_mem_pkg::opsize_e  size_in,
    input  logic [`RM_XLEN-1:0]    addr_in,
    input  logic [`RM_XLEN-1:0]    end_addr_in,
    input  logic [`RM_XLEN-1:0]    store_data_in,
    input  logic [`RM_RIDX_W-1:0]  dest_in,
    input  logic [`RM_XLEN-1:0]    eip_in,

    output logic                   valid_out,
    output rrag_mem_pkg::mem_op_e  op_out,
    output rrag_mem_pkg::opsize_e  size_out,
    output logic [`RM_XLEN-1:0]    addr_out,
    output logic [`RM_XLEN-1:0]    end_addr_out,
    output logic [`RM_XLEN-1:0]    store_data_out,
    output logic [`RM_RIDX_W-1:0]  dest_out,
    output logic [`RM_XLEN-1:0]    eip_out
);

    logic ld;
    logic valid_q;

    // stall wins over flush.
    assign ld = ~stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (ld) begin
            valid_q <= valid_in & ~flush;
        end
    end

    // payload keeps its old value on a flush.
    always_ff @(posedge clk) begin
        if (ld && !flush) begin
            op_out         <= op_in;
            size_out       <= size_in;
            addr_out       <= addr_in;
            end_addr_out   <= end_addr_in;
            store_data_out <= store_data_in;
            dest_out       <= dest_in;
            eip_out        <= eip_in;
        end
    end

    // a flush also kills the instruction the memory stage is about to
    // start, so neither its store nor its result happens.
    assign valid_out = valid_q & (stall | ~flush);

endmodule

// File: mem_stage.sv
`include "rrag_mem_defs.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   valid,
    input  rrag_mem_pkg::mem_op_e  op,
    input  rrag_mem_pkg::opsize_e  size,
    input  logic [`RM_XLEN-1:0]    addr,
    input  logic [`RM_XLEN-1:0]    end_addr,
    input  logic [`RM_XLEN-1:0]    store_data,
    input  logic [`RM_RIDX_W-1:0]  dest,
    input  logic [`RM_XLEN-1:0]    eip,
    output logic                   stall,
    output logic                   res_valid,
    output logic [`RM_XLEN-1:0]    res_data,
    output logic [`RM_RIDX_W-1:0]  res_dest,
    output logic [`RM_XLEN-1:0]    res_eip
);

    rrag_mem_pkg::mem_state_e state_q;
    rrag_mem_pkg::mem_op_e    sv_op, cur_op;
    rrag_mem_pkg::opsize_e    sv_size, cur_size;
    logic [`RM_XLEN-1:0]      sv_addr, cur_addr;
    logic [`RM_XLEN-1:0]      sv_store_data, cur_store_data;
    logic [`RM_RIDX_W-1:0]    sv_dest, cur_dest;
    logic [`RM_XLEN-1:0]      sv_eip, cur_eip;
    logic                     in_second, first_go, split, done;

    logic [`RM_XLEN-1:0]      mem [0:`RM_MEM_WORDS-1];
    logic [`RM_MEM_AW-1:0]    cur_word, next_word;
    logic [1:0]               cur_off;
    logic [`RM_XLEN-1:0]      rd_lo, rd_hi, lo_word_q, size_mask;
    logic [`RM_LANES-1:0]     lane_mask;
    logic [2*`RM_XLEN-1:0]    load_wide, store_wide;
    logic [2*`RM_LANES-1:0]   be_wide;
    logic                     wr_en;
    logic [`RM_MEM_AW-1:0]    wr_word;
    logic [`RM_LANES-1:0]     wr_be;
    logic [`RM_XLEN-1:0]      wr_data;

    assign in_second = (state_q == rrag_mem_pkg::st_second);
    assign stall     = in_second;
    assign first_go  = valid && !in_second;
    // lea forms only an address and never takes a second cycle.
    assign split     = (op != rrag_mem_pkg::op_lea)
                    && (addr[`RM_XLEN-1:2] != end_addr[`RM_XLEN-1:2]);
    assign done      = in_second || (first_go && !split);

    // second cycle works from the copy taken in the first.
    assign cur_op         = in_second ? sv_op : op;
    assign cur_size       = in_second ? sv_size : size;
    assign cur_addr       = in_second ? sv_addr : addr;
    assign cur_store_data = in_second ? sv_store_data : store_data;
    assign cur_dest       = in_second ? sv_dest : dest;
    assign cur_eip        = in_second ? sv_eip : eip;

    assign cur_word  = cur_addr[`RM_MEM_AW+1:2];
    assign next_word = cur_word + 1'b1;
    assign cur_off   = cur_addr[1:0];

    always_comb begin
        case (cur_size)
            rrag_mem_pkg::size_byte: begin
                lane_mask = 4'b0001;
                size_mask = 32'h0000_00ff;
            end
            rrag_mem_pkg::size_word: begin
                lane_mask = 4'b0011;
                size_mask = 32'h0000_ffff;
            end
            default: begin
                lane_mask = 4'b1111;
                size_mask = 32'hffff_ffff;
            end
        endcase
    end

    // the upper word of the little-endian pair is the one after the split.
    assign rd_lo      = in_second ? lo_word_q : mem[cur_word];
    assign rd_hi      = mem[next_word];
    assign load_wide  = {rd_hi, rd_lo} >> {cur_off, 3'b000};
    assign store_wide = {{`RM_XLEN{1'b0}}, cur_store_data} << {cur_off, 3'b000};
    assign be_wide    = {{`RM_LANES{1'b0}}, lane_mask} << cur_off;

    assign wr_en   = (first_go || in_second) && (cur_op == rrag_mem_pkg::op_store);
    assign wr_word = in_second ? next_word : cur_word;
    assign wr_be   = in_second ? be_wide[2*`RM_LANES-1:`RM_LANES] : be_wide[`RM_LANES-1:0];
    assign wr_data = in_second ? store_wide[2*`RM_XLEN-1:`RM_XLEN] : store_wide[`RM_XLEN-1:0];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < `RM_LANES; i++) begin
                if (wr_be[i]) begin
                    mem[wr_word][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= rrag_mem_pkg::st_access;
            res_valid <= 1'b0;
        end else begin
            state_q   <= (first_go && split) ? rrag_mem_pkg::st_second
                                             : rrag_mem_pkg::st_access;
            // stores produce no result.
            res_valid <= done && (cur_op != rrag_mem_pkg::op_store);
        end
    end

    always_ff @(posedge clk) begin
        if (first_go && split) begin
            sv_op         <= op;
            sv_size       <= size;
            sv_addr       <= addr;
            sv_store_data <= store_data;
            sv_dest       <= dest;
            sv_eip        <= eip;
            lo_word_q     <= rd_lo;
        end
        if (done) begin
            res_data <= (cur_op == rrag_mem_pkg::op_lea) ? cur_addr
                                                         : load_wide[`RM_XLEN-1:0] & size_mask;
            res_dest <= cur_dest;
            res_eip  <= cur_eip;
        end
    end

endmodule

// File: rrag_mem_top.sv
`include "rrag_mem_defs.svh"

module rrag_mem_top (
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic                   in_valid,
    input  rrag_mem_pkg::mem_op_e  in_op,
    input  rrag_mem_pkg::opsize_e  in_size,
    input  logic [`RM_RIDX_W-1:0]  base_idx,
    input  logic [`RM_RIDX_W-1:0]  index_idx,
    input  logic [1:0]             scale,
    input  logic [`RM_XLEN-1:0]    disp,
    input  logic [`RM_SIDX_W-1:0]  seg_sel,
    input  logic [`RM_RIDX_W-1:0]  data_idx,
    input  logic [`RM_RIDX_W-1:0]  dest_idx,
    input  logic [`RM_XLEN-1:0]    eip,
    input  logic                   flush,

    input  logic                   wb_en,
    input  logic [`RM_RIDX_W-1:0]  wb_idx,
    input  logic [`RM_XLEN-1:0]    wb_data,
    input  logic                   seg_wr_en,
    input  logic [`RM_SIDX_W-1:0]  seg_wr_idx,
    input  logic [`RM_XLEN-1:0]    seg_wr_data,

    output logic                   stall,
    output logic                   res_valid,
    output logic [`RM_XLEN-1:0]    res_data,
    output logic [`RM_RIDX_W-1:0]  res_dest,
    output logic [`RM_XLEN-1:0]    res_eip
);

    logic                  rr_valid, lt_valid;
    rrag_mem_pkg::mem_op_e rr_op, lt_op;
    rrag_mem_pkg::opsize_e rr_size, lt_size;
    logic [`RM_XLEN-1:0]   rr_addr, lt_addr, rr_end_addr, lt_end_addr;
    logic [`RM_XLEN-1:0]   rr_store_data, lt_store_data, rr_eip, lt_eip;
    logic [`RM_RIDX_W-1:0] rr_dest, lt_dest;

    rrag_stage u_rrag (
        .clk(clk), .arst_n(arst_n),
        .in_valid(in_valid), .in_op(in_op), .in_size(in_size),
        .base_idx(base_idx), .index_idx(index_idx), .scale(scale), .disp(disp),
        .seg_sel(seg_sel), .data_idx(data_idx), .dest_idx(dest_idx), .eip(eip),
        .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data),
        .seg_wr_en(seg_wr_en), .seg_wr_idx(seg_wr_idx), .seg_wr_data(seg_wr_data),
        .valid_out(rr_valid), .op_out(rr_op), .size_out(rr_size),
        .addr_out(rr_addr), .end_addr_out(rr_end_addr),
        .store_data_out(rr_store_data), .dest_out(rr_dest), .eip_out(rr_eip)
    );

    rrag_mem_latch u_latch (
        .clk(clk), .arst_n(arst_n), .stall(stall), .flush(flush),
        .valid_in(rr_valid), .op_in(rr_op), .size_in(rr_size),
        .addr_in(rr_addr), .end_addr_in(rr_end_addr),
        .store_data_in(rr_store_data), .dest_in(rr_dest), .eip_in(rr_eip),
        .valid_out(lt_valid), .op_out(lt_op), .size_out(lt_size),
        .addr_out(lt_addr), .end_addr_out(lt_end_addr),
        .store_data_out(lt_store_data), .dest_out(lt_dest), .eip_out(lt_eip)
    );

    mem_stage u_mem (
        .clk(clk), .arst_n(arst_n),
        .valid(lt_valid), .op(lt_op), .size(lt_size),
        .addr(lt_addr), .end_addr(lt_end_addr), .store_data(lt_store_data),
        .dest(lt_dest), .eip(lt_eip),
        .stall(stall), .res_valid(res_valid), .res_data(res_data),
        .res_dest(res_dest), .res_eip(res_eip)
    );

endmodule

// File: tb_rrag_mem.sv
`include "rrag_mem_defs.svh"

module tb_rrag_mem;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 100;

    logic                  clk;
    logic                  arst_n;
    logic                  in_valid;
    rrag_mem_pkg::mem_op_e in_op;
    rrag_mem_pkg::opsize_e in_size;
    logic [`RM_RIDX_W-1:0] base_idx, index_idx, data_idx, dest_idx, wb_idx;
    logic [1:0]            scale;
    logic [`RM_SIDX_W-1:0] seg_sel, seg_wr_idx;
    logic [`RM_XLEN-1:0]   disp, eip, wb_data, seg_wr_data;
    logic                  flush, wb_en, seg_wr_en, stall, res_valid;
    logic [`RM_XLEN-1:0]   res_data, res_eip;
    logic [`RM_RIDX_W-1:0] res_dest;

    // reference copies of registers, segment bases and memory bytes.
    logic [`RM_XLEN-1:0]   ref_gpr [0:`RM_NREGS-1];
    logic [`RM_XLEN-1:0]   ref_seg [0:`RM_NSEGS-1];
    logic [7:0]            ref_mem [0:4*`RM_MEM_WORDS-1];

    // expected results in issue order.
    logic [`RM_XLEN-1:0]   exp_data[$], exp_eip[$];
    logic [`RM_RIDX_W-1:0] exp_dest[$];
    int                    exp_edge[$];

    int                    seed, edge_cnt, last_done, exp_at;
    logic [`RM_XLEN-1:0]   next_eip;
    logic                  saw_stall;

    rrag_mem_top uut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    always @(negedge clk) begin
        if (stall === 1'b1) begin
            saw_stall = 1'b1;
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [`RM_XLEN-1:0] got,
                              input logic [`RM_XLEN-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_idx(input string name, input logic [`RM_RIDX_W-1:0] got,
                             input logic [`RM_RIDX_W-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic int size_bytes(input rrag_mem_pkg::opsize_e size);
        if (size == rrag_mem_pkg::size_byte) begin
            return 1;
        end
        return (size == rrag_mem_pkg::size_word) ? 2 : 4;
    endfunction

    // segment + base + index * 2^scale + disp modulo 2^32.
    function automatic logic [`RM_XLEN-1:0] ref_lin_addr(input logic [2:0] b,
            input logic [2:0] x, input logic [1:0] sc, input logic [`RM_XLEN-1:0] d,
            input logic [1:0] sg);
        logic [`RM_XLEN-1:0] scaled;
        scaled = ref_gpr[x] << sc;
        return ref_seg[sg] + ref_gpr[b] + scaled + d;
    endfunction

    function automatic logic [`RM_XLEN-1:0] ref_result(input rrag_mem_pkg::mem_op_e op,
            input rrag_mem_pkg::opsize_e size, input logic [`RM_XLEN-1:0] lin);
        logic [`RM_XLEN-1:0] val;
        val = '0;
        if (op == rrag_mem_pkg::op_lea) begin
            return lin;
        end
        for (int k = 0; k < size_bytes(size); k++) begin
            val[8*k +: 8] = ref_mem[(lin + k) & 32'h3ff];
        end
        return val;
    endfunction

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (edge_cnt < last_done || stall === 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_now("timed out waiting for the pipe to drain");
            end
        end
    endtask

    task automatic write_state(input logic to_seg, input logic [2:0] idx,
                               input logic [`RM_XLEN-1:0] val);
        wait_idle();
        if (to_seg) begin
            seg_wr_en = 1'b1;
            seg_wr_idx = idx[1:0];
            seg_wr_data = val;
            ref_seg[idx[1:0]] = val;
        end else begin
            wb_en = 1'b1;
            wb_idx = idx;
            wb_data = val;
            ref_gpr[idx] = val;
        end
        @(negedge clk);
        wb_en = 1'b0;
        seg_wr_en = 1'b0;
    endtask

    // drives one instruction from a falling edge and holds it until the pipe takes it.
    task automatic issue(input rrag_mem_pkg::mem_op_e op, input rrag_mem_pkg::opsize_e size,
            input logic [2:0] b, input logic [2:0] x, input logic [1:0] sc,
            input logic [`RM_XLEN-1:0] d, input logic [1:0] sg, input logic [2:0] src,
            input logic [2:0] dst, input logic keep);
        logic [`RM_XLEN-1:0] lin;
        logic split_acc;
        int start, waited, n;
        lin = ref_lin_addr(b, x, sc, d, sg);
        n = size_bytes(size);
        // lea reads no memory, so only loads and stores cross into a second word.
        split_acc = (op != rrag_mem_pkg::op_lea) && ((lin >> 2) != ((lin + n - 1) >> 2));
        in_valid = 1'b1;
        in_op = op;
        in_size = size;
        base_idx = b;
        index_idx = x;
        scale = sc;
        disp = d;
        seg_sel = sg;
        data_idx = src;
        dest_idx = dst;
        eip = next_eip;
        waited = 0;
        while (stall === 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_now("timed out waiting for stall to drop before issue");
            end
        end
        if (keep) begin
            // memory stage is free once the previous access is done.
            start = (edge_cnt + 1 > last_done) ? edge_cnt + 1 : last_done;
            last_done = start + 1 + (split_acc ? 1 : 0);
            if (op == rrag_mem_pkg::op_store) begin
                for (int k = 0; k < n; k++) begin
                    ref_mem[(lin + k) & 32'h3ff] = ref_gpr[src][8*k +: 8];
                end
            end else begin
                exp_data.push_back(ref_result(op, size, lin));
                exp_dest.push_back(dst);
                exp_eip.push_back(next_eip);
                exp_edge.push_back(last_done);
            end
        end
        next_eip = next_eip + 4;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // base 0x40, index 0x8 scaled by 4 and segment 0x1000 add up to 0x1060.
    task automatic access(input rrag_mem_pkg::mem_op_e op, input rrag_mem_pkg::opsize_e size,
            input logic [9:0] addr, input logic [2:0] src, input logic [2:0] dst,
            input logic keep);
        issue(op, size, 3'd1, 3'd2, 2'd2, {22'd0, addr} - 32'h60, 2'd1, src, dst, keep);
    endtask

    task automatic fill_memory(input logic zero);
        logic [7:0] w;
        write_state(1'b1, 3'd1, 32'h0000_1000);
        write_state(1'b0, 3'd1, 32'h0000_0040);
        write_state(1'b0, 3'd2, 32'h0000_0008);
        for (int i = 0; i < `RM_MEM_WORDS; i++) begin
            w = i[7:0];
            write_state(1'b0, 3'd7, zero ? '0 : {w ^ 8'ha5, ~w, w + 8'h3c, w});
            access(rrag_mem_pkg::op_store, rrag_mem_pkg::size_dword, {w, 2'b00}, 3'd7, 3'd0, 1'b1);
        end
    endtask

    task automatic randomize_state();
        for (int r = 0; r < `RM_NREGS; r++) begin
            write_state(1'b0, r[2:0], $random(seed));
        end
        for (int s = 0; s < `RM_NSEGS; s++) begin
            write_state(1'b1, s[2:0], $random(seed));
        end
    endtask

    task automatic random_issue(input logic lea_only);
        rrag_mem_pkg::mem_op_e op;
        rrag_mem_pkg::opsize_e size;
        logic [31:0] r;
        r = $random(seed);
        op = rrag_mem_pkg::mem_op_e'((r[1:0] == 2'd3) ? 2'd1 : r[1:0]);
        if (lea_only) begin
            op = rrag_mem_pkg::op_lea;
        end
        size = rrag_mem_pkg::opsize_e'((r[3:2] == 2'd3) ? 2'd2 : r[3:2]);
        issue(op, size, r[6:4], r[9:7], r[11:10], $random(seed), r[13:12], r[16:14],
              r[19:17], 1'b1);
    endtask

    // each result is checked against the oldest expectation.
    always @(negedge clk) begin
        if (arst_n === 1'b1 && res_valid === 1'b1) begin
            if (exp_data.size() == 0) begin
                fail_now("a result appeared with no instruction pending");
            end else begin
                exp_at = exp_edge.pop_front();
                if (exp_at != edge_cnt) begin
                    fail_now($sformatf("result arrived at edge %0d instead of edge %0d",
                                       edge_cnt, exp_at));
                end
                check_data("res_data", res_data, exp_data.pop_front());
                check_idx("res_dest", res_dest, exp_dest.pop_front());
                check_data("res_eip", res_eip, exp_eip.pop_front());
            end
        end
    end

    initial begin
        int waited;
        seed = 18;
        edge_cnt = 0;
        last_done = 0;
        next_eip = 32'h0000_1000;
        saw_stall = 1'b0;
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_op = rrag_mem_pkg::op_lea;
        in_size = rrag_mem_pkg::size_byte;
        base_idx = '0;
        index_idx = '0;
        scale = '0;
        disp = '0;
        seg_sel = '0;
        data_idx = '0;
        dest_idx = '0;
        eip = '0;
        flush = 1'b0;
        wb_en = 1'b0;
        wb_idx = '0;
        wb_data = '0;
        seg_wr_en = 1'b0;
        seg_wr_idx = '0;
        seg_wr_data = '0;
        for (int r = 0; r < `RM_NREGS; r++) begin
            ref_gpr[r] = '0;
        end
        for (int s = 0; s < `RM_NSEGS; s++) begin
            ref_seg[s] = '0;
        end
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        check_flag("stall", stall, 1'b0);
        check_flag("res_valid", res_valid, 1'b0);
        @(negedge clk);
        check_flag("stall", stall, 1'b0);
        check_flag("res_valid", res_valid, 1'b0);

        // zeroed memory reads back zero.
        fill_memory(1'b1);
        access(rrag_mem_pkg::op_load, rrag_mem_pkg::size_dword, 10'h010, 3'd0, 3'd4, 1'b1);

        // aligned stores of each size.
        write_state(1'b0, 3'd5, 32'h8bad_f00d);
        access(rrag_mem_pkg::op_store, rrag_mem_pkg::size_dword, 10'h020, 3'd5, 3'd0, 1'b1);
        access(rrag_mem_pkg::op_load, rrag_mem_pkg::size_dword, 10'h020, 3'd0, 3'd1, 1'b1);
        access(rrag_mem_pkg::op_store, rrag_mem_pkg::size_word, 10'h026, 3'd5, 3'd0, 1'b1);
        access(rrag_mem_pkg::op_load, rrag_mem_pkg::size_word, 10'h026, 3'd0, 3'd2, 1'b1);
        access(rrag_mem_pkg::op_load, rrag_mem_pkg::size_dword, 10'h024, 3'd0, 3'd3, 1'b1);
        access(rrag_mem_pkg::op_store, rrag_mem_pkg::size_byte, 10'h02b, 3'd5, 3'd0, 1'b1);
        access(rrag_mem_pkg::op_load, rrag_mem_pkg::size_byte, 10'h02b, 3'd0, 3'd5, 1'b1);
        access(rrag_mem_pkg::op_load, rrag_mem_pkg::size_dword, 10'h028, 3'd0, 3'd6, 1'b1);

        // split stores followed by loads that wait out the stall.
        write_state(1'b0, 3'd6, 32'hc0ff_ee11);
        wait_idle();
        saw_stall = 1'b0;
        access(rrag_mem_pkg::op_store, rrag_mem_pkg::size_dword, 10'h031, 3'd6, 3'd0, 1'b1);
        access(rrag_mem_pkg::op_load, rrag_mem_pkg::size_dword, 10'h031, 3'd0, 3'd1, 1'b1);
        access(rrag_mem_pkg::op_load, rrag_mem_pkg::size_dword, 10'h030, 3'd0, 3'd2, 1'b1);
        access(rrag_mem_pkg::op_load, rrag_mem_pkg::size_dword, 10'h034, 3'd0, 3'd3, 1'b1);
        access(rrag_mem_pkg::op_store, rrag_mem_pkg::size_word, 10'h047, 3'd6, 3'd0, 1'b1);
        access(rrag_mem_pkg::op_load, rrag_mem_pkg::size_word, 10'h047, 3'd0, 3'd4, 1'b1);
        access(rrag_mem_pkg::op_load, rrag_mem_pkg::size_dword, 10'h044, 3'd0, 3'd5, 1'b1);
        access(rrag_mem_pkg::op_store, rrag_mem_pkg::size_dword, 10'h3fe, 3'd6, 3'd0, 1'b1);
        access(rrag_mem_pkg::op_load, rrag_mem_pkg::size_dword, 10'h3fe, 3'd0, 3'd6, 1'b1);
        access(rrag_mem_pkg::op_load, rrag_mem_pkg::size_dword, 10'h000, 3'd0, 3'd7, 1'b1);
        wait_idle();
        if (!saw_stall) begin
            fail_now("stall never went high during the split accesses");
        end

        // flushed store and lea leave no trace.
        write_state(1'b0, 3'd5, 32'hdead_beef);
        access(rrag_mem_pkg::op_store, rrag_mem_pkg::size_dword, 10'h050, 3'd5, 3'd0, 1'b0);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        access(rrag_mem_pkg::op_lea, rrag_mem_pkg::size_dword, 10'h054, 3'd0, 3'd2, 1'b0);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        access(rrag_mem_pkg::op_load, rrag_mem_pkg::size_dword, 10'h050, 3'd0, 3'd3, 1'b1);

        // random lea followed by a random mix over a patterned memory.
        randomize_state();
        repeat (24) random_issue(1'b1);
        fill_memory(1'b0);
        repeat (3) begin
            randomize_state();
            repeat (40) random_issue(1'b0);
        end

        wait_idle();
        waited = 0;
        while (exp_data.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_now("timed out waiting for the last results");
            end
        end
        repeat (4) @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: rrag_mem.f
+incdir+.
rrag_mem_pkg.sv
reg_file.sv
addr_gen.sv
rrag_stage.sv
rrag_mem_latch.sv
mem_stage.sv
rrag_mem_top.sv
tb_rrag_mem.sv
